// ==== design/spi_link_pkg.sv ====
// spi link constants for pin filtering, bit counting and the sck watchdog
`default_nettype none

package spi_link_pkg;

	// ------------------------------
	// pin synchronizer and filter
	// ------------------------------

	// flops in the synchronizer chain
	localparam int SYNC_STAGES = 2;

	// equal samples needed before the filtered level moves
	localparam int FILTER_LEN = 3;
	localparam int FILT_CNT_WIDTH = $clog2(FILTER_LEN);

	// ------------------------------
	// byte framing
	// ------------------------------

	localparam int BITS_PER_BYTE = 8;
	localparam int BIT_CNT_WIDTH = $clog2(BITS_PER_BYTE);

	// sck stall limit, 10 us at 100 MHz
	localparam int WD_CYCLES = 1000;
	localparam int WD_WIDTH = 10;

endpackage

`default_nettype wire

// ==== design/ctrl_cmd_pkg.sv ====
// control command package with opcodes, header layout and event queue sizing
`default_nettype none

package ctrl_cmd_pkg;

	// ------------------------------
	// basic types
	// ------------------------------

	typedef logic [7:0] byte_t;
	typedef logic [5:0] cmd_addr_t;

	// opcode in the top two bits of the header
	typedef enum logic [1:0] {
		OP_NOP    = 2'b00,
		OP_WR_INC = 2'b01,
		OP_WR_FIX = 2'b10,
		OP_RSVD   = 2'b11
	} cmd_op_t;

	typedef struct packed {
		cmd_op_t   op;
		cmd_addr_t addr;
	} cmd_hdr_t;

	// first byte of a frame is a header, the rest are plain data
	typedef union packed {
		cmd_hdr_t hdr;
		byte_t    raw;
	} ctrl_byte_u;

	// ------------------------------
	// credit flow and queue
	// ------------------------------

	localparam int CREDIT_INIT = 4;
	localparam int CREDIT_WIDTH = 3;

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_WIDTH = QUEUE_PTR_WIDTH + 1;

endpackage

`default_nettype wire

// ==== design/pin_sync.sv ====
// pin synchronizer with run-length glitch filter and edge pulses
`default_nettype none
`timescale 1ns/100ps

module pin_sync (
	input  wire  clk_sys,
	input  wire  rst_n,
	input  wire  pin,
	output logic level,
	output logic rise,
	output logic fall
);

	logic [spi_link_pkg::SYNC_STAGES-1:0]    sync_q;
	logic [spi_link_pkg::FILT_CNT_WIDTH-1:0] run_cnt;
	logic                                    sample;
	logic                                    flip;

	assign sample = sync_q[spi_link_pkg::SYNC_STAGES-1];

	// level moves on the last of FILTER_LEN differing samples
	assign flip = (sample != level) &&
		(run_cnt == spi_link_pkg::FILT_CNT_WIDTH'(spi_link_pkg::FILTER_LEN - 1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sync_q  <= '0;
			run_cnt <= '0;
			level   <= 1'b0;
			rise    <= 1'b0;
			fall    <= 1'b0;
		end else begin
			sync_q <= {sync_q[spi_link_pkg::SYNC_STAGES-2:0], pin};
			rise   <= flip && sample;
			fall   <= flip && !sample;
			if (sample == level) begin
				// run broken, start over
				run_cnt <= '0;
			end else if (flip) begin
				level   <= sample;
				run_cnt <= '0;
			end else begin
				run_cnt <= run_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/spi_byte_rx.sv ====
// spi mode 0 byte receiver with bit counter and sck stall watchdog
`default_nettype none
`timescale 1ns/100ps

module spi_byte_rx (
	input  wire                 clk_sys,
	input  wire                 rst_n,
	input  wire                 csn,
	input  wire                 sck_rise,
	input  wire                 mosi,
	output ctrl_cmd_pkg::byte_t rx_byte,
	output logic                rx_valid
);

	logic [spi_link_pkg::BIT_CNT_WIDTH-1:0] bit_cnt;
	logic [spi_link_pkg::WD_WIDTH-1:0]      wd_cnt;
	ctrl_cmd_pkg::byte_t                    shift_q;
	logic                                   last_bit;
	logic                                   wd_expire;
	logic                                   take_bit;

	assign take_bit = sck_rise && !csn;
	assign last_bit = (bit_cnt ==
		spi_link_pkg::BIT_CNT_WIDTH'(spi_link_pkg::BITS_PER_BYTE - 1));
	assign wd_expire = (wd_cnt ==
		spi_link_pkg::WD_WIDTH'(spi_link_pkg::WD_CYCLES));

	// ------------------------------
	// shift register
	// ------------------------------

	// msb first, newest bit at the bottom
	always_ff @(posedge clk_sys) begin
		if (take_bit) begin
			shift_q <= {shift_q[6:0], mosi};
		end
	end

	// ------------------------------
	// bit counter and watchdog
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (csn || wd_expire) begin
			bit_cnt <= '0;
		end else if (take_bit) begin
			bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
		end
	end

	// counts only while a byte is partly in
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wd_cnt <= '0;
		end else if (csn || sck_rise || wd_expire || (bit_cnt == '0)) begin
			wd_cnt <= '0;
		end else begin
			wd_cnt <= wd_cnt + 1'b1;
		end
	end

	// ------------------------------
	// byte output
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= take_bit && last_bit;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take_bit && last_bit) begin
			rx_byte <= {shift_q[6:0], mosi};
		end
	end

	// a deselected link never carries a partial byte forward
	a_csn_clears_bits : assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		csn |=> (bit_cnt == '0)
	);

endmodule

`default_nettype wire

// ==== design/cmd_decoder.sv ====
// command decoder turning spi frames into register write events
`default_nettype none
`timescale 1ns/100ps

module cmd_decoder (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire                     frame_start,
	input  wire                     frame_end,
	input  ctrl_cmd_pkg::byte_t     rx_byte,
	input  wire                     rx_valid,
	output logic                    wr_valid,
	output ctrl_cmd_pkg::cmd_addr_t wr_addr,
	output ctrl_cmd_pkg::byte_t     wr_data,
	output logic                    cmd_err
);

	enum logic [1:0] {
		ST_IDLE,
		ST_HEADER,
		ST_DATA
	} state;

	ctrl_cmd_pkg::ctrl_byte_u rx_word;
	ctrl_cmd_pkg::cmd_op_t    op_q;
	ctrl_cmd_pkg::cmd_addr_t  addr_q;
	logic                     is_write;
	logic                     data_wr;

	assign rx_word = rx_byte;
	assign is_write = (op_q == ctrl_cmd_pkg::OP_WR_INC) ||
		(op_q == ctrl_cmd_pkg::OP_WR_FIX);
	assign data_wr = (state == ST_DATA) && rx_valid && is_write;

	// ------------------------------
	// frame FSM
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			op_q    <= ctrl_cmd_pkg::OP_NOP;
			addr_q  <= '0;
			cmd_err <= 1'b0;
		end else begin
			cmd_err <= 1'b0;
			if (frame_end) begin
				state <= ST_IDLE;
			end else if (frame_start) begin
				state <= ST_HEADER;
			end else begin
				case (state)
					ST_HEADER: begin
						if (rx_valid) begin
							op_q    <= rx_word.hdr.op;
							addr_q  <= rx_word.hdr.addr;
							cmd_err <= (rx_word.hdr.op == ctrl_cmd_pkg::OP_RSVD);
							state   <= ST_DATA;
						end
					end
					ST_DATA: begin
						// 6-bit address wraps from 63 to 0
						if (data_wr && (op_q == ctrl_cmd_pkg::OP_WR_INC)) begin
							addr_q <= addr_q + 1'b1;
						end
					end
					default: begin
						state <= ST_IDLE;
					end
				endcase
			end
		end
	end

	// ------------------------------
	// write events
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_valid <= 1'b0;
		end else begin
			wr_valid <= data_wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_wr) begin
			wr_addr <= addr_q;
			wr_data <= rx_word.raw;
		end
	end

	a_no_write_outside_data : assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		wr_valid |-> (state != ST_IDLE) && (state != ST_HEADER)
	);

endmodule

`default_nettype wire

// ==== design/event_credit_tx.sv ====
// write event queue with credit counter and credit-gated send
`default_nettype none
`timescale 1ns/100ps

module event_credit_tx (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire                     wr_valid,
	input  ctrl_cmd_pkg::cmd_addr_t wr_addr,
	input  ctrl_cmd_pkg::byte_t     wr_data,
	input  wire                     credit_return,
	output logic                    ev_valid,
	output ctrl_cmd_pkg::cmd_addr_t ev_addr,
	output ctrl_cmd_pkg::byte_t     ev_data,
	output logic                    ev_overflow
);

	ctrl_cmd_pkg::cmd_addr_t q_addr [ctrl_cmd_pkg::QUEUE_DEPTH];
	ctrl_cmd_pkg::byte_t     q_data [ctrl_cmd_pkg::QUEUE_DEPTH];

	logic [ctrl_cmd_pkg::QUEUE_PTR_WIDTH-1:0] wr_ptr;
	logic [ctrl_cmd_pkg::QUEUE_PTR_WIDTH-1:0] rd_ptr;
	logic [ctrl_cmd_pkg::QUEUE_CNT_WIDTH-1:0] q_count;
	logic [ctrl_cmd_pkg::CREDIT_WIDTH-1:0]    credit_cnt;
	logic                                     q_full;
	logic                                     send;
	logic                                     push;

	assign q_full = (q_count ==
		ctrl_cmd_pkg::QUEUE_CNT_WIDTH'(ctrl_cmd_pkg::QUEUE_DEPTH));

	// head of queue goes out whenever a credit is held
	assign send = (q_count != '0) && (credit_cnt != '0);
	// a send in the same cycle frees the slot
	assign push = wr_valid && (!q_full || send);

	assign ev_valid = send;
	assign ev_addr  = q_addr[rd_ptr];
	assign ev_data  = q_data[rd_ptr];

	// ------------------------------
	// ring buffer
	// ------------------------------

	always_ff @(posedge clk_sys) begin
		if (push) begin
			q_addr[wr_ptr] <= wr_addr;
			q_data[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (send) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, send})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
		end
	end

	// ------------------------------
	// credits and overflow
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= ctrl_cmd_pkg::CREDIT_WIDTH'(ctrl_cmd_pkg::CREDIT_INIT);
		end else begin
			case ({credit_return, send})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// sticky until reset
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ev_overflow <= 1'b0;
		end else if (wr_valid && !push) begin
			ev_overflow <= 1'b1;
		end
	end

	// consumer must not return more than it took
	a_credit_bound : assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		credit_cnt <= ctrl_cmd_pkg::CREDIT_WIDTH'(ctrl_cmd_pkg::CREDIT_INIT)
	);

	// credits only come back through credit_return
	a_no_send_without_credit : assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(credit_cnt == '0) && !credit_return |=> !ev_valid
	);

endmodule

`default_nettype wire

// ==== design/spi_ctrl_top.sv ====
// spi control receiver top joining pin filters, byte receiver, decoder and sender
`default_nettype none
`timescale 1ns/100ps

module spi_ctrl_top (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire                     spi_csn,
	input  wire                     spi_sck,
	input  wire                     spi_mosi,
	input  wire                     credit_return,
	output logic                    ev_valid,
	output ctrl_cmd_pkg::cmd_addr_t ev_addr,
	output ctrl_cmd_pkg::byte_t     ev_data,
	output logic                    ev_overflow,
	output logic                    cmd_err
);

	logic                    csn_level;
	logic                    csn_rise;
	logic                    csn_fall;
	logic                    sck_rise;
	logic                    mosi_level;
	ctrl_cmd_pkg::byte_t     rx_byte;
	logic                    rx_valid;
	logic                    wr_valid;
	ctrl_cmd_pkg::cmd_addr_t wr_addr;
	ctrl_cmd_pkg::byte_t     wr_data;

	// ------------------------------
	// pin conditioning
	// ------------------------------

	pin_sync u_sync_csn (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.pin     (spi_csn),
		.level   (csn_level),
		.rise    (csn_rise),
		.fall    (csn_fall)
	);

	// only rising sck matters in mode 0
	pin_sync u_sync_sck (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.pin     (spi_sck),
		.level   (),
		.rise    (sck_rise),
		.fall    ()
	);

	pin_sync u_sync_mosi (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.pin     (spi_mosi),
		.level   (mosi_level),
		.rise    (),
		.fall    ()
	);

	// ------------------------------
	// byte, command and event path
	// ------------------------------

	spi_byte_rx u_byte_rx (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.csn      (csn_level),
		.sck_rise (sck_rise),
		.mosi     (mosi_level),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	// csn fall opens a frame, csn rise closes it
	cmd_decoder u_decoder (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.frame_start (csn_fall),
		.frame_end   (csn_rise),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.wr_valid    (wr_valid),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.cmd_err     (cmd_err)
	);

	event_credit_tx u_credit_tx (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.wr_valid      (wr_valid),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.credit_return (credit_return),
		.ev_valid      (ev_valid),
		.ev_addr       (ev_addr),
		.ev_data       (ev_data),
		.ev_overflow   (ev_overflow)
	);

endmodule

`default_nettype wire

// ==== verification/tb_clkgen.sv ====
// testbench clock and reset source, 10 ns clock with reset held for 10 cycles
`default_nettype none
`timescale 1ns/100ps

module tb_clkgen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// release on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verification/tb_spi_ctrl.sv ====
// testbench that replays golden spi frames and checks write events and flags
`default_nettype none
`timescale 1ns/100ps

module tb_spi_ctrl;

	localparam int EVENT_WAIT = 2000;
	localparam int CYCLES_PER_RECORD = 3000;

	logic                    clk_sys;
	logic                    rst_n;
	logic                    spi_csn;
	logic                    spi_sck;
	logic                    spi_mosi;
	logic                    credit_return = 1'b0;
	logic                    ev_valid;
	ctrl_cmd_pkg::cmd_addr_t ev_addr;
	ctrl_cmd_pkg::byte_t     ev_data;
	logic                    ev_overflow;
	logic                    cmd_err;

	// golden records, one entry per data line
	logic [7:0]  rec_kind [$];
	logic [31:0] rec_a [$];
	logic [31:0] rec_b [$];
	logic [31:0] rec_c [$];

	// events seen by the consumer, read back in order
	ctrl_cmd_pkg::cmd_addr_t obs_addr [$];
	ctrl_cmd_pkg::byte_t     obs_data [$];
	int                      obs_rd;

	logic        hold = 1'b0;
	logic        golden_loaded = 1'b0;
	logic [31:0] lfsr;
	int          owed;
	int          err_pulses;
	int          err_base;
	int          watchdog_ns;
	int          errors;
	int          events_checked;
	int          flags_checked;

	tb_clkgen u_clkgen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	spi_ctrl_top uut (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.spi_csn       (spi_csn),
		.spi_sck       (spi_sck),
		.spi_mosi      (spi_mosi),
		.credit_return (credit_return),
		.ev_valid      (ev_valid),
		.ev_addr       (ev_addr),
		.ev_data       (ev_data),
		.ev_overflow   (ev_overflow),
		.cmd_err       (cmd_err)
	);

	// ------------------------------
	// sck timing
	// ------------------------------

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// 8 to 11 cycles, always longer than the pin filter
	task automatic wait_half();
		int cycles;
		cycles = 8 + 2 * int'(lfsr[0]);
		lfsr = lfsr_step(lfsr);
		cycles = cycles + int'(lfsr[0]);
		lfsr = lfsr_step(lfsr);
		repeat (cycles) @(posedge clk_sys);
	endtask

	// mode 0, msb first, sck back low after each bit
	task automatic send_bits(input ctrl_cmd_pkg::byte_t value, input int nbits);
		ctrl_cmd_pkg::byte_t shift;
		int i;
		shift = value;
		for (i = 0; i < nbits; i++) begin
			@(posedge clk_sys);
			spi_mosi <= shift[7];
			shift = shift << 1;
			wait_half();
			spi_sck <= 1'b1;
			wait_half();
			spi_sck <= 1'b0;
		end
	endtask

	// ------------------------------
	// golden file
	// ------------------------------

	task automatic load_golden();
		int          fd;
		int          n;
		string       line;
		logic [7:0]  kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen("verification/spi_ctrl_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/spi_ctrl_golden.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
				a = '0;
				b = '0;
				c = '0;
				n = $sscanf(line, "%c %h %h %h", kind, a, b, c);
				rec_kind.push_back(kind);
				rec_a.push_back(a);
				rec_b.push_back(b);
				rec_c.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------
	// compare tasks
	// ------------------------------

	task automatic check_event(
		input ctrl_cmd_pkg::cmd_addr_t exp_addr,
		input ctrl_cmd_pkg::byte_t     exp_data,
		input ctrl_cmd_pkg::cmd_addr_t got_addr,
		input ctrl_cmd_pkg::byte_t     got_data
	);
		events_checked++;
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			$display("FAIL %0t ns: event expected addr %h data %h, got addr %h data %h",
				$time, exp_addr, exp_data, got_addr, got_data);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic got);
		flags_checked++;
		if (got !== expected) begin
			$display("FAIL %0t ns: %s expected %b, got %b", $time, name, expected, got);
			errors++;
		end
	endtask

	// ------------------------------
	// record handlers
	// ------------------------------

	task automatic expect_event(
		input ctrl_cmd_pkg::cmd_addr_t exp_addr,
		input ctrl_cmd_pkg::byte_t     exp_data
	);
		int                      waited;
		ctrl_cmd_pkg::cmd_addr_t got_addr;
		ctrl_cmd_pkg::byte_t     got_data;
		waited = 0;
		@(negedge clk_sys);
		while (obs_addr.size() == obs_rd && waited < EVENT_WAIT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (obs_addr.size() == obs_rd) begin
			$display("event for address %h with data %h never arrived", exp_addr, exp_data);
			errors++;
		end else begin
			got_addr = obs_addr[obs_rd];
			got_data = obs_data[obs_rd];
			obs_rd++;
			check_event(exp_addr, exp_data, got_addr, got_data);
		end
	endtask

	// flag 0 is ev_overflow, flag 1 any cmd_err pulse since the last look
	task automatic expect_flag(input logic [31:0] which, input logic expected);
		@(negedge clk_sys);
		if (which == 0) begin
			check_flag("ev_overflow", expected, ev_overflow);
		end else begin
			check_flag("cmd_err", expected, err_pulses != err_base);
			err_base = err_pulses;
		end
	endtask

	// all earlier credits go back before holding
	task automatic hold_credits();
		@(negedge clk_sys);
		while (owed != 0) begin
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		hold <= 1'b1;
	endtask

	task automatic run_record(input int idx);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		a = rec_a[idx];
		b = rec_b[idx];
		c = rec_c[idx];
		case (rec_kind[idx])
			"S": begin
				@(posedge clk_sys);
				spi_csn <= 1'b0;
				repeat (16) @(posedge clk_sys);
			end
			"E": begin
				repeat (16) @(posedge clk_sys);
				spi_csn <= 1'b1;
				repeat (16) @(posedge clk_sys);
			end
			"B": send_bits(a[7:0], 8);
			"P": begin
				send_bits(b[7:0], int'(a));
				repeat (c) @(posedge clk_sys);
			end
			"H": hold_credits();
			"R": begin
				@(posedge clk_sys);
				hold <= 1'b0;
			end
			"X": expect_event(a[5:0], b[7:0]);
			"F": expect_flag(a, b[0]);
			default: begin
				$display("golden record %0d has an unknown kind", idx);
				errors++;
			end
		endcase
	endtask

	// ------------------------------
	// consumer side monitor
	// ------------------------------

	// one credit back per event unless held
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			credit_return <= 1'b0;
			owed = 0;
		end else begin
			if (ev_valid) begin
				obs_addr.push_back(ev_addr);
				obs_data.push_back(ev_data);
				owed++;
			end
			if (cmd_err) begin
				err_pulses++;
			end
			if (owed > 0 && !hold) begin
				credit_return <= 1'b1;
				owed--;
			end else begin
				credit_return <= 1'b0;
			end
		end
	end

	// ------------------------------
	// main flow and watchdog
	// ------------------------------

	initial begin : main_flow
		int idx;
		spi_csn  = 1'b1;
		spi_sck  = 1'b0;
		spi_mosi = 1'b0;
		lfsr     = 32'h1338;
		load_golden();
		watchdog_ns = (rec_kind.size() + 20) * CYCLES_PER_RECORD * 10;
		golden_loaded = 1'b1;
		@(posedge rst_n);
		// csn filter settles on the idle level first
		repeat (20) @(posedge clk_sys);
		for (idx = 0; idx < rec_kind.size(); idx++) begin
			run_record(idx);
		end
		repeat (100) @(posedge clk_sys);
		@(negedge clk_sys);
		if (obs_addr.size() != obs_rd) begin
			$display("%0d events arrived that were never expected", obs_addr.size() - obs_rd);
			errors++;
		end
		$display("errors %0d, events checked %0d, flags checked %0d",
			errors, events_checked, flags_checked);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		wait (golden_loaded);
		#(watchdog_ns);
		$display("run did not finish within %0d ns and was stopped", watchdog_ns);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/spi_ctrl_golden.txt ====
# kind and hex fields: S csn low, E csn high, B byte, P nbits value stall_cycles
# H hold credits, R release credits, X addr data, F flag value (0 ev_overflow, 1 cmd_err)
S
B 45
B 11
B 22
B 33
E
X 05 11
X 06 22
X 07 33
S
B 7f
B a1
B a2
E
X 3f a1
X 00 a2
S
B 92
B c3
B 3c
B 5a
E
X 12 c3
X 12 3c
X 12 5a
S
B 09
B 77
B 88
E
F 1 0
S
B d5
B 99
E
F 1 1
S
B 8a
P 3 a0 4b0
B e7
E
X 0a e7
S
B 4c
B 10
P 5 f8 0
E
X 0c 10
S
B a0
B 6b
E
X 20 6b
F 0 0
H
S
B 70
B 01
B 02
B 03
B 04
B 05
B 06
B 07
B 08
B 09
B 0a
E
X 30 01
X 31 02
X 32 03
X 33 04
F 0 1
R
X 34 05
X 35 06
X 36 07
X 37 08

// ==== sim.f ====
design/spi_link_pkg.sv
design/ctrl_cmd_pkg.sv
design/pin_sync.sv
design/spi_byte_rx.sv
design/cmd_decoder.sv
design/event_credit_tx.sv
design/spi_ctrl_top.sv
verification/tb_clkgen.sv
verification/tb_spi_ctrl.sv

// ==== Makefile ====
TOP = tb_spi_ctrl

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o sim_top
	./obj_dir/sim_top | awk '{ print } /^TEST OK$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
